// ==== common/vlsu_pkg.sv ====
// VLSU shared definitions
// AXI4 channel payloads, request and segment formats, queue entry layout
// and the configuration register image used across the memory front end

package vlsu_pkg;

  // ==============================
  // Bus and queue dimensions
  // ==============================
  localparam int unsigned axi_data_width     = 64;
  localparam int unsigned axi_addr_width     = 32;
  localparam int unsigned beat_bytes         = 8;
  // AXI size code for 8-byte beats
  localparam int unsigned axi_size_beat      = 3;
  // Bursts never cross this boundary
  localparam int unsigned page_bytes         = 4096;
  localparam int unsigned txn_ctrl_num       = 4;
  localparam int unsigned txn_ptr_width      = 2;
  // Burst cap register address
  localparam int unsigned cfg_addr_max_beats = 0;

  // AXI burst type, only INCR is ever issued
  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } axi_burst_e;

  // ==============================
  // Request and segment formats
  // ==============================
  // Unit-stride request from the core, len is beat count minus one
  typedef struct packed {
    logic [axi_addr_width-1:0] addr;
    logic [7:0]                len;
    logic                      is_load;
  } vlsu_req_t;

  // One burst-sized piece of a request
  typedef struct packed {
    logic [axi_addr_width-1:0] addr;
    logic [7:0]                len;
    logic                      is_load;
    // Last segment of its request
    logic                      is_final;
  } meta_seg_t;

  // Transaction queue entry
  typedef struct packed {
    logic [axi_addr_width-1:0] addr;
    logic [7:0]                len;
    logic [2:0]                size;
    // Beats still to move, minus one
    logic [7:0]                rmn_beat;
    // No beat moved yet
    logic                      is_head;
    logic                      is_load;
    logic                      is_final;
  } txn_ctrl_t;

  // ==============================
  // AXI4 channel payloads
  // ==============================
  typedef struct packed {
    logic                      id;
    logic [axi_addr_width-1:0] addr;
    logic [7:0]                len;
    logic [2:0]                size;
    axi_burst_e                burst;
    logic [3:0]                cache;
  } axi_ax_t;

  typedef struct packed {
    logic [axi_data_width-1:0]   data;
    logic [axi_data_width/8-1:0] strb;
    logic                        last;
  } axi_w_t;

  typedef struct packed {
    logic [axi_data_width-1:0] data;
    logic [1:0]                resp;
    logic                      last;
  } axi_r_t;

  // Configuration image, cap of 1 to 16 beats
  typedef struct packed {
    logic [3:0] max_beats_m1;
  } cfg_t;

endpackage

// ==== hw/vlsu_cfg_regs.sv ====
// VLSU configuration registers
// Holds the burst cap, written through a single-cycle strobe.
// The cap register stores beats minus one, so a write of 3 means 4 beats

`timescale 1ns/1ps

module vlsu_cfg_regs (
  input  logic              clk_i,
  input  logic              rst_ni,
  // Strobe write port
  input  logic              cfg_we_i,
  input  logic [3:0]        cfg_addr_i,
  input  logic [31:0]       cfg_wdata_i,
  // Current configuration
  output vlsu_pkg::cfg_t    cfg_o
);

  import vlsu_pkg::*;

  cfg_t       cfg_q;
  logic       cap_sel;
  logic [3:0] cap_wdata;

  // Address decode
  assign cap_sel = cfg_we_i && (cfg_addr_i == 4'(cfg_addr_max_beats));

  // Clamp oversized writes to the widest cap
  always_comb begin
    if (|cfg_wdata_i[31:4]) begin
      cap_wdata = 4'hf;
    end else begin
      cap_wdata = cfg_wdata_i[3:0];
    end
  end

  // Default cap of 16 beats
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_q.max_beats_m1 <= 4'hf;
    end else if (cap_sel) begin
      cfg_q.max_beats_m1 <= cap_wdata;
    end
  end

  assign cfg_o = cfg_q;

endmodule

// ==== hw/vlsu_seg_split.sv ====
// VLSU segment splitter
// Cuts one unit-stride request into AXI-sized segments. Each segment is
// bounded by the remaining beats, the burst cap and the next 4 KiB page

`timescale 1ns/1ps

module vlsu_seg_split (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  vlsu_pkg::cfg_t        cfg_i,
  // Request from the core
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  input  vlsu_pkg::vlsu_req_t   req_i,
  // Segments to the transaction queue
  output logic                  meta_valid_o,
  input  logic                  meta_ready_i,
  output vlsu_pkg::meta_seg_t   meta_o
);

  import vlsu_pkg::*;

  // Control state
  logic                      busy_q;
  // Request payload being split
  logic [axi_addr_width-1:0] cur_addr_q;
  logic [7:0]                rmn_m1_q;
  logic                      is_load_q;
  logic [3:0]                cap_m1_q;

  // Segment sizing
  logic [$clog2(page_bytes/beat_bytes)-1:0] page_off;
  logic [$clog2(page_bytes/beat_bytes)-1:0] page_left_m1;
  logic [8:0]                               seg_len_m1;
  logic [8:0]                               seg_beats;
  logic                                     seg_final;
  logic                                     req_fire;
  logic                                     seg_fire;

  assign req_ready_o  = !busy_q;
  assign req_fire     = req_valid_i && req_ready_o;
  assign meta_valid_o = busy_q;
  assign seg_fire     = meta_valid_o && meta_ready_i;

  // Beat index within the current page
  assign page_off     = cur_addr_q[$clog2(beat_bytes) +: $clog2(page_bytes/beat_bytes)];
  // Beats up to the page end, minus one
  assign page_left_m1 = ~page_off;

  // Smallest of remaining beats, cap and page room
  always_comb begin
    seg_len_m1 = {1'b0, rmn_m1_q};
    if ({5'd0, cap_m1_q} < seg_len_m1) begin
      seg_len_m1 = {5'd0, cap_m1_q};
    end
    if (page_left_m1 < seg_len_m1) begin
      seg_len_m1 = page_left_m1;
    end
  end

  assign seg_beats = seg_len_m1 + 9'd1;
  assign seg_final = (seg_len_m1 == {1'b0, rmn_m1_q});

  // Segment presented straight from the held state
  assign meta_o.addr     = cur_addr_q;
  assign meta_o.len      = seg_len_m1[7:0];
  assign meta_o.is_load  = is_load_q;
  assign meta_o.is_final = seg_final;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
    end else if (req_fire) begin
      busy_q <= 1'b1;
    end else if (seg_fire && seg_final) begin
      busy_q <= 1'b0;
    end
  end

  // Cap is latched per request so the presented segment stays stable
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      cur_addr_q <= req_i.addr;
      rmn_m1_q   <= req_i.len;
      is_load_q  <= req_i.is_load;
      cap_m1_q   <= cfg_i.max_beats_m1;
    end else if (seg_fire) begin
      // Step past the emitted burst
      cur_addr_q <= cur_addr_q + (axi_addr_width'(seg_beats) << $clog2(beat_bytes));
      rmn_m1_q   <= rmn_m1_q - seg_beats[7:0];
    end
  end

endmodule

// ==== hw/txn_ctrl/txn_ctrl_unit.sv ====
// Transaction control unit
// Four-entry circular queue of AXI bursts with enqueue, issue, data and
// dequeue pointers. Issues AR/AW in order, tracks beats of the entry at
// the data pointer and retires stores on B

`timescale 1ns/1ps

module txn_ctrl_unit (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Segments from the splitter
  input  logic                  meta_valid_i,
  output logic                  meta_ready_o,
  input  vlsu_pkg::meta_seg_t   meta_i,
  // Entry at the data pointer
  output logic                  txn_ctrl_valid_o,
  output vlsu_pkg::txn_ctrl_t   txn_ctrl_o,
  output logic                  addr_issued_o,
  input  logic                  update_i,
  // AXI AW
  output logic                  aw_valid_o,
  input  logic                  aw_ready_i,
  output vlsu_pkg::axi_ax_t     aw_o,
  // AXI AR
  output logic                  ar_valid_o,
  input  logic                  ar_ready_i,
  output vlsu_pkg::axi_ax_t     ar_o,
  // AXI B
  input  logic                  b_valid_i,
  output logic                  b_ready_o,
  output logic                  req_done_o
);

  import vlsu_pkg::*;

  // Wrap flag plus slot index
  typedef struct packed {
    logic                     flag;
    logic [txn_ptr_width-1:0] value;
  } ptr_t;

  function automatic ptr_t ptr_inc(ptr_t p);
    ptr_t n;
    n = p;
    if (p.value == txn_ptr_width'(txn_ctrl_num - 1)) begin
      n.value = '0;
      n.flag  = ~p.flag;
    end else begin
      n.value = p.value + 1'b1;
    end
    return n;
  endfunction

  ptr_t      enq_ptr_q, iss_ptr_q, data_ptr_q, deq_ptr_q;
  txn_ctrl_t q_mem [txn_ctrl_num];
  txn_ctrl_t enq_entry;
  txn_ctrl_t iss_entry;
  txn_ctrl_t deq_entry;
  axi_ax_t   ax_req;
  logic      empty, full;
  logic      do_enq, do_iss, do_deq, data_ptr_add;
  logic      ax_valid, b_fire;

  // ==============================
  // Queue status
  // ==============================
  assign empty = (enq_ptr_q == deq_ptr_q);
  assign full  = (enq_ptr_q.value == deq_ptr_q.value) && (enq_ptr_q.flag != deq_ptr_q.flag);

  assign iss_entry = q_mem[iss_ptr_q.value];
  assign deq_entry = q_mem[deq_ptr_q.value];

  assign meta_ready_o = !full;
  assign do_enq       = meta_valid_i && meta_ready_o;

  // Fresh entry from a segment
  always_comb begin
    enq_entry          = '0;
    enq_entry.addr     = meta_i.addr;
    enq_entry.len      = meta_i.len;
    enq_entry.size     = 3'(axi_size_beat);
    enq_entry.rmn_beat = meta_i.len;
    enq_entry.is_head  = 1'b1;
    enq_entry.is_load  = meta_i.is_load;
    enq_entry.is_final = meta_i.is_final;
  end

  // ==============================
  // Address issue
  // ==============================
  // Entries between issue and enqueue still need AR or AW
  assign ax_valid   = (iss_ptr_q != enq_ptr_q);
  assign ar_valid_o = ax_valid &&  iss_entry.is_load;
  assign aw_valid_o = ax_valid && !iss_entry.is_load;
  assign do_iss     = (ar_valid_o && ar_ready_i) || (aw_valid_o && aw_ready_i);

  always_comb begin
    ax_req       = '0;
    ax_req.id    = 1'b0;
    ax_req.addr  = iss_entry.addr;
    ax_req.len   = iss_entry.len;
    ax_req.size  = iss_entry.size;
    ax_req.burst = BURST_INCR;
    // Normal non-cacheable modifiable
    ax_req.cache = 4'b0010;
  end

  assign ar_o = ax_req;
  assign aw_o = ax_req;

  // ==============================
  // Data and retire
  // ==============================
  assign txn_ctrl_valid_o = (data_ptr_q != enq_ptr_q);
  assign txn_ctrl_o       = q_mem[data_ptr_q.value];
  assign addr_issued_o    = (iss_ptr_q != data_ptr_q);
  // Last beat of the data-pointer entry
  assign data_ptr_add     = update_i && (txn_ctrl_o.rmn_beat == 8'd0);

  // Store retires on B once all its W beats are out
  assign b_ready_o = !empty && !deq_entry.is_load && (data_ptr_q != deq_ptr_q);
  assign b_fire    = b_valid_i && b_ready_o;

  // Load retires with its last R beat, or later if a store held the queue
  always_comb begin
    do_deq = 1'b0;
    if (!empty) begin
      if (deq_entry.is_load) begin
        do_deq = (data_ptr_q != deq_ptr_q) || data_ptr_add;
      end else begin
        do_deq = b_fire;
      end
    end
  end

  // Pointer counters
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      enq_ptr_q  <= '0;
      iss_ptr_q  <= '0;
      data_ptr_q <= '0;
      deq_ptr_q  <= '0;
      req_done_o <= 1'b0;
    end else begin
      if (do_enq) enq_ptr_q <= ptr_inc(enq_ptr_q);
      if (do_iss) iss_ptr_q <= ptr_inc(iss_ptr_q);
      if (data_ptr_add) data_ptr_q <= ptr_inc(data_ptr_q);
      if (do_deq) deq_ptr_q <= ptr_inc(deq_ptr_q);
      // One pulse per retired final burst
      req_done_o <= do_deq && deq_entry.is_final;
    end
  end

  // Entry storage, enqueue and data slots never coincide while both act
  always_ff @(posedge clk_i) begin
    if (do_enq) begin
      q_mem[enq_ptr_q.value] <= enq_entry;
    end
    if (update_i && !data_ptr_add) begin
      q_mem[data_ptr_q.value].rmn_beat <= txn_ctrl_o.rmn_beat - 8'd1;
      q_mem[data_ptr_q.value].is_head  <= 1'b0;
    end
  end

endmodule

// ==== hw/vlsu_beat_track.sv ====
// VLSU beat tracker
// Steers R beats to the core and core store data onto W for the entry at
// the data pointer, and pulses an update for every moved beat

`timescale 1ns/1ps

module vlsu_beat_track (
  // Entry at the data pointer
  input  logic                                txn_ctrl_valid_i,
  input  vlsu_pkg::txn_ctrl_t                 txn_ctrl_i,
  input  logic                                addr_issued_i,
  output logic                                update_o,
  // AXI R
  input  logic                                r_valid_i,
  output logic                                r_ready_o,
  input  vlsu_pkg::axi_r_t                    r_i,
  // Load data to the core
  output logic                                ld_valid_o,
  output logic [vlsu_pkg::axi_data_width-1:0] ld_data_o,
  // AXI W
  output logic                                w_valid_o,
  input  logic                                w_ready_i,
  output vlsu_pkg::axi_w_t                    w_o,
  // Store data from the core
  input  logic                                st_valid_i,
  output logic                                st_ready_o,
  input  logic [vlsu_pkg::axi_data_width-1:0] st_data_i
);

  import vlsu_pkg::*;

  logic is_ld_entry;
  logic is_st_entry;
  logic r_fire;
  logic w_fire;

  // Direction of the current entry
  assign is_ld_entry = txn_ctrl_valid_i &&  txn_ctrl_i.is_load;
  assign is_st_entry = txn_ctrl_valid_i && !txn_ctrl_i.is_load;

  // ==============================
  // Load path
  // ==============================
  // R only flows while a load is at the data pointer
  assign r_ready_o  = is_ld_entry;
  assign r_fire     = r_valid_i && r_ready_o;

  // No ready toward the core, R back-pressure covers it
  assign ld_valid_o = r_fire;
  assign ld_data_o  = r_i.data;

  // ==============================
  // Store path
  // ==============================
  // W waits until the AW of this burst has gone out
  assign w_valid_o  = st_valid_i && is_st_entry && addr_issued_i;
  assign w_fire     = w_valid_o && w_ready_i;
  assign st_ready_o = w_fire;

  always_comb begin
    w_o      = '0;
    w_o.data = st_data_i;
    // Full-width beats only
    w_o.strb = '1;
    w_o.last = (txn_ctrl_i.rmn_beat == 8'd0);
  end

  // One pulse per beat in either direction
  assign update_o = r_fire || w_fire;

endmodule

// ==== hw/vlsu_top.sv ====
// VLSU memory front end top level
// Configuration, segment splitter, transaction queue and beat tracker
// between the vector core and a 64-bit AXI4 port

`timescale 1ns/1ps

module vlsu_top (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // Configuration strobe
  input  logic                                cfg_we_i,
  input  logic [3:0]                          cfg_addr_i,
  input  logic [31:0]                         cfg_wdata_i,
  // Core request
  input  logic                                req_valid_i,
  output logic                                req_ready_o,
  input  vlsu_pkg::vlsu_req_t                 req_i,
  output logic                                req_done_o,
  // Core data
  input  logic                                st_valid_i,
  output logic                                st_ready_o,
  input  logic [vlsu_pkg::axi_data_width-1:0] st_data_i,
  output logic                                ld_valid_o,
  output logic [vlsu_pkg::axi_data_width-1:0] ld_data_o,
  // AXI4 master
  output logic                                aw_valid_o,
  input  logic                                aw_ready_i,
  output vlsu_pkg::axi_ax_t                   aw_o,
  output logic                                ar_valid_o,
  input  logic                                ar_ready_i,
  output vlsu_pkg::axi_ax_t                   ar_o,
  output logic                                w_valid_o,
  input  logic                                w_ready_i,
  output vlsu_pkg::axi_w_t                    w_o,
  input  logic                                r_valid_i,
  output logic                                r_ready_o,
  input  vlsu_pkg::axi_r_t                    r_i,
  input  logic                                b_valid_i,
  output logic                                b_ready_o
);

  import vlsu_pkg::*;

  cfg_t      cfg;
  logic      meta_valid, meta_ready;
  meta_seg_t meta_seg;
  logic      txn_ctrl_valid, addr_issued, beat_update;
  txn_ctrl_t txn_ctrl;

  vlsu_cfg_regs i_cfg_regs (
    .clk_i, .rst_ni, .cfg_we_i, .cfg_addr_i, .cfg_wdata_i,
    .cfg_o (cfg)
  );

  vlsu_seg_split i_seg_split (
    .clk_i, .rst_ni,
    .cfg_i        (cfg),
    .req_valid_i, .req_ready_o, .req_i,
    .meta_valid_o (meta_valid),
    .meta_ready_i (meta_ready),
    .meta_o       (meta_seg)
  );

  txn_ctrl_unit i_txn_ctrl (
    .clk_i, .rst_ni,
    .meta_valid_i     (meta_valid),
    .meta_ready_o     (meta_ready),
    .meta_i           (meta_seg),
    .txn_ctrl_valid_o (txn_ctrl_valid),
    .txn_ctrl_o       (txn_ctrl),
    .addr_issued_o    (addr_issued),
    .update_i         (beat_update),
    .aw_valid_o, .aw_ready_i, .aw_o,
    .ar_valid_o, .ar_ready_i, .ar_o,
    .b_valid_i, .b_ready_o, .req_done_o
  );

  vlsu_beat_track i_beat_track (
    .txn_ctrl_valid_i (txn_ctrl_valid),
    .txn_ctrl_i       (txn_ctrl),
    .addr_issued_i    (addr_issued),
    .update_o         (beat_update),
    .r_valid_i, .r_ready_o, .r_i,
    .ld_valid_o, .ld_data_o,
    .w_valid_o, .w_ready_i, .w_o,
    .st_valid_i, .st_ready_o, .st_data_i
  );

endmodule

// ==== dv/vlsu_checker.sv ====
// VLSU protocol checker
// Bound into the top level. Watches AXI valid/ready stability, 4 KiB page
// limits, done pulses against accepted requests and queue pointer order

`timescale 1ns/1ps

module vlsu_checker (
  input logic              clk_i,
  input logic              rst_ni,
  input logic              req_valid_i,
  input logic              req_ready_o,
  input logic              req_done_o,
  input logic              ar_valid_o,
  input logic              ar_ready_i,
  input vlsu_pkg::axi_ax_t ar_o,
  input logic              aw_valid_o,
  input logic              aw_ready_i,
  input vlsu_pkg::axi_ax_t aw_o,
  input logic              w_valid_o,
  input logic              w_ready_i,
  input vlsu_pkg::axi_w_t  w_o,
  input logic              r_ready_o,
  input logic              b_ready_o,
  input logic              ld_valid_o,
  // Queue pointers, wrap flag on top
  input logic [2:0]        enq_ptr_i,
  input logic [2:0]        iss_ptr_i,
  input logic [2:0]        data_ptr_i,
  input logic [2:0]        deq_ptr_i
);

  import vlsu_pkg::*;

  int unsigned fail_cnt = 0;
  int unsigned open_reqs;
  logic [12:0] ar_end, aw_end;
  logic [2:0]  fill, iss_fill, data_fill;

  // Byte offset just past the burst, within its page
  assign ar_end = {1'b0, ar_o.addr[11:0]} + {2'b00, ar_o.len, 3'b000} + 13'd8;
  assign aw_end = {1'b0, aw_o.addr[11:0]} + {2'b00, aw_o.len, 3'b000} + 13'd8;

  // Distances from the dequeue pointer
  assign fill      = enq_ptr_i - deq_ptr_i;
  assign iss_fill  = iss_ptr_i - deq_ptr_i;
  assign data_fill = data_ptr_i - deq_ptr_i;

  // Accepted requests not yet reported done
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      open_reqs <= 0;
    end else begin
      open_reqs <= open_reqs + 32'(req_valid_i && req_ready_o) - 32'(req_done_o);
    end
  end

  reset_state: assert property (@(posedge clk_i) !rst_ni |-> req_ready_o && !ar_valid_o &&
      !aw_valid_o && !w_valid_o && !r_ready_o && !b_ready_o && !ld_valid_o && !req_done_o)
    else begin $error("control outputs active during reset"); fail_cnt++; end

  ar_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
      ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_o))
    else begin $error("AR dropped or changed before ready"); fail_cnt++; end

  aw_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
      aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_o))
    else begin $error("AW dropped or changed before ready"); fail_cnt++; end

  w_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
      w_valid_o && !w_ready_i |=> w_valid_o && $stable(w_o))
    else begin $error("W dropped or changed before ready"); fail_cnt++; end

  ar_page: assert property (@(posedge clk_i) disable iff (!rst_ni)
      ar_valid_o |-> ar_end <= 13'd4096)
    else begin $error("AR burst crosses a 4 KiB page"); fail_cnt++; end

  aw_page: assert property (@(posedge clk_i) disable iff (!rst_ni)
      aw_valid_o |-> aw_end <= 13'd4096)
    else begin $error("AW burst crosses a 4 KiB page"); fail_cnt++; end

  done_once: assert property (@(posedge clk_i) disable iff (!rst_ni)
      req_done_o |-> open_reqs != 0)
    else begin $error("done pulse without an open request"); fail_cnt++; end

  ptr_order: assert property (@(posedge clk_i) disable iff (!rst_ni)
      fill <= 3'd4 && data_fill <= iss_fill && iss_fill <= fill)
    else begin $error("queue pointers out of order"); fail_cnt++; end

endmodule

bind vlsu_top vlsu_checker i_checker (
  .clk_i, .rst_ni, .req_valid_i, .req_ready_o, .req_done_o,
  .ar_valid_o, .ar_ready_i, .ar_o, .aw_valid_o, .aw_ready_i, .aw_o,
  .w_valid_o, .w_ready_i, .w_o, .r_ready_o, .b_ready_o, .ld_valid_o,
  .enq_ptr_i  (i_txn_ctrl.enq_ptr_q),
  .iss_ptr_i  (i_txn_ctrl.iss_ptr_q),
  .data_ptr_i (i_txn_ctrl.data_ptr_q),
  .deq_ptr_i  (i_txn_ctrl.deq_ptr_q)
);

// ==== dv/tb_vlsu.sv ====
// VLSU testbench
// Drives core requests and store data, models an AXI4 memory that returns
// each beat's own address as read data, and compares all traffic

`timescale 1ns/1ps

module tb_vlsu;

  import vlsu_pkg::*;

  // Beats per test: 40, 20, 10, 24+12+30+17, 9
  localparam int unsigned total_beats    = 40 + 20 + 10 + 83 + 9;
  localparam int unsigned timeout_cycles = 64 * total_beats + 200;

  logic        clk_i = 1'b0;
  logic        rst_ni;
  logic        cfg_we_i;
  logic [3:0]  cfg_addr_i;
  logic [31:0] cfg_wdata_i;
  logic        req_valid_i, req_ready_o, req_done_o;
  vlsu_req_t   req_i;
  logic        st_valid_i, st_ready_o, ld_valid_o;
  logic [63:0] st_data_i, ld_data_o;
  logic        aw_valid_o, aw_ready_i, ar_valid_o, ar_ready_i;
  axi_ax_t     aw_o, ar_o;
  logic        w_valid_o, w_ready_i, r_valid_i, r_ready_o, b_valid_i, b_ready_o;
  axi_w_t      w_o;
  axi_r_t      r_i;

  // Observed and expected traffic
  axi_ax_t     ar_log[$], aw_log[$], exp_ar[$], exp_aw[$], r_pend[$];
  logic [63:0] ld_log[$], exp_ld[$], w_log[$], exp_w[$], st_q[$];
  logic        wlast_log[$], exp_wlast[$];
  logic [7:0]  wstrb_log[$];

  int unsigned r_beat       = 0;
  int unsigned b_pend       = 0;
  int unsigned done_cnt     = 0;
  int unsigned req_sent     = 0;
  int unsigned cycles       = 0;
  int unsigned errors       = 0;
  int unsigned tests_run    = 0;
  int unsigned tests_failed = 0;
  int unsigned cur_cap      = 16;
  int unsigned st_idx       = 0;
  logic        throttle     = 1'b0;
  logic [31:0] lfsr         = 32'h5facc483;

  vlsu_top i_vlsu_top (.*);

  always #4 clk_i = ~clk_i;

  // Fibonacci LFSR, taps 32 22 2 1, one step per ready bit
  function automatic logic draw_bit();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic int unsigned checker_fails();
    return i_vlsu_top.i_checker.fail_cnt;
  endfunction

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got == exp) else begin
      $display("MISMATCH t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
      errors++;
    end
  endtask

  // Reference split: min of beats left, cap and room to the 4 KiB page
  task automatic add_expect(input logic [31:0] addr, input int unsigned nbeats,
                            input logic is_load);
    axi_ax_t     ax;
    int unsigned left, seg, room;
    left = nbeats;
    while (left != 0) begin
      room = (4096 - (addr % 4096)) / 8;
      seg  = left;
      if (cur_cap < seg) seg = cur_cap;
      if (room < seg) seg = room;
      ax      = '0;
      ax.addr = addr;
      ax.len  = 8'(seg - 1);
      if (is_load) exp_ar.push_back(ax);
      else exp_aw.push_back(ax);
      for (int i = 0; i < seg; i++) begin
        if (is_load) begin
          exp_ld.push_back(64'(addr) + 64'(i * 8));
        end else begin
          st_q.push_back({32'h57a7_0000 + 32'(st_idx), ~32'(st_idx)});
          exp_w.push_back({32'h57a7_0000 + 32'(st_idx), ~32'(st_idx)});
          exp_wlast.push_back(i == seg - 1);
          st_idx++;
        end
      end
      addr = addr + 32'(seg * 8);
      left = left - seg;
    end
  endtask

  task automatic run_req(input logic [31:0] addr, input int unsigned nbeats,
                         input logic is_load);
    @(negedge clk_i);
    add_expect(addr, nbeats, is_load);
    @(posedge clk_i);
    #1;
    req_valid_i   = 1'b1;
    req_i.addr    = addr;
    req_i.len     = 8'(nbeats - 1);
    req_i.is_load = is_load;
    do @(negedge clk_i); while (!req_ready_o);
    @(posedge clk_i);
    #1;
    req_valid_i = 1'b0;
    req_sent++;
  endtask

  task automatic write_cfg(input logic [3:0] addr, input logic [31:0] data);
    @(posedge clk_i);
    #1;
    cfg_we_i    = 1'b1;
    cfg_addr_i  = addr;
    cfg_wdata_i = data;
    @(posedge clk_i);
    #1;
    cfg_we_i = 1'b0;
    if (addr == 4'(cfg_addr_max_beats)) cur_cap = (data > 15) ? 16 : data + 1;
  endtask

  task automatic wait_done();
    while (done_cnt < req_sent) begin
      @(posedge clk_i);
      #2;
    end
  endtask

  task automatic finish_test(input string name, input int unsigned start_errs);
    int unsigned errs;
    repeat (4) @(posedge clk_i);
    #2;
    check_val("req_done_o count", done_cnt, req_sent);
    check_val("AR count", ar_log.size(), exp_ar.size());
    check_val("AW count", aw_log.size(), exp_aw.size());
    check_val("ld_valid_o count", ld_log.size(), exp_ld.size());
    check_val("W count", w_log.size(), exp_w.size());
    for (int i = 0; i < ar_log.size() && i < exp_ar.size(); i++) begin
      check_val("ar_o.id", ar_log[i].id, 0);
      check_val("ar_o.addr", ar_log[i].addr, exp_ar[i].addr);
      check_val("ar_o.len", ar_log[i].len, exp_ar[i].len);
      check_val("ar_o.size", ar_log[i].size, 3);
      check_val("ar_o.burst", ar_log[i].burst, BURST_INCR);
    end
    for (int i = 0; i < aw_log.size() && i < exp_aw.size(); i++) begin
      check_val("aw_o.id", aw_log[i].id, 0);
      check_val("aw_o.addr", aw_log[i].addr, exp_aw[i].addr);
      check_val("aw_o.len", aw_log[i].len, exp_aw[i].len);
      check_val("aw_o.size", aw_log[i].size, 3);
      check_val("aw_o.burst", aw_log[i].burst, BURST_INCR);
    end
    for (int i = 0; i < ld_log.size() && i < exp_ld.size(); i++) begin
      check_val("ld_data_o", ld_log[i], exp_ld[i]);
    end
    for (int i = 0; i < w_log.size() && i < exp_w.size(); i++) begin
      check_val("w_o.data", w_log[i], exp_w[i]);
      check_val("w_o.last", wlast_log[i], exp_wlast[i]);
      check_val("w_o.strb", wstrb_log[i], 8'hff);
    end
    ar_log.delete();
    aw_log.delete();
    ld_log.delete();
    w_log.delete();
    wlast_log.delete();
    wstrb_log.delete();
    exp_ar.delete();
    exp_aw.delete();
    exp_ld.delete();
    exp_w.delete();
    exp_wlast.delete();
    errs = errors + checker_fails() - start_errs;
    tests_run++;
    if (errs != 0) tests_failed++;
    $display("test %-14s %s (%0d errors)", name, (errs == 0) ? "ok" : "failed", errs);
  endtask

  // ==============================
  // AXI memory model
  // ==============================
  // Handshakes sampled mid-cycle, responses driven just after the edge
  always begin : axi_memory
    logic ar_f, aw_f, w_f, wl, r_f, b_f, st_f;
    @(negedge clk_i);
    ar_f = ar_valid_o && ar_ready_i;
    aw_f = aw_valid_o && aw_ready_i;
    w_f  = w_valid_o && w_ready_i;
    wl   = w_o.last;
    r_f  = r_valid_i && r_ready_o;
    b_f  = b_valid_i && b_ready_o;
    st_f = st_valid_i && st_ready_o;
    if (ar_f) begin
      ar_log.push_back(ar_o);
      r_pend.push_back(ar_o);
    end
    if (aw_f) aw_log.push_back(aw_o);
    if (w_f) begin
      w_log.push_back(w_o.data);
      wlast_log.push_back(wl);
      wstrb_log.push_back(w_o.strb);
    end
    if (ld_valid_o) ld_log.push_back(ld_data_o);
    if (req_done_o) done_cnt++;
    @(posedge clk_i);
    #1;
    if (r_f) begin
      if (r_beat == 32'(r_pend[0].len)) begin
        void'(r_pend.pop_front());
        r_beat = 0;
      end else begin
        r_beat++;
      end
    end
    // B follows the last W beat of a burst
    if (w_f && wl) b_pend++;
    if (b_f) b_pend--;
    if (st_f) void'(st_q.pop_front());
    r_valid_i = (r_pend.size() != 0);
    if (r_valid_i) begin
      r_i.data = 64'(r_pend[0].addr) + 64'(r_beat * 8);
      r_i.resp = 2'b00;
      r_i.last = (r_beat == 32'(r_pend[0].len));
    end
    b_valid_i  = (b_pend != 0);
    st_valid_i = (st_q.size() != 0);
    st_data_i  = st_valid_i ? st_q[0] : '0;
    if (throttle) begin
      ar_ready_i = draw_bit();
      aw_ready_i = draw_bit();
      w_ready_i  = draw_bit();
    end else begin
      ar_ready_i = 1'b1;
      aw_ready_i = 1'b1;
      w_ready_i  = 1'b1;
    end
  end

  always @(posedge clk_i) begin : watchdog
    cycles++;
    if (cycles >= timeout_cycles) begin
      $display("Timeout after %0d cycles, requests did not complete", cycles);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // ==============================
  // Test sequence
  // ==============================
  initial begin : stimulus
    int unsigned start;
    rst_ni      = 1'b0;
    cfg_we_i    = 1'b0;
    cfg_addr_i  = '0;
    cfg_wdata_i = '0;
    req_valid_i = 1'b0;
    req_i       = '0;
    st_valid_i  = 1'b0;
    st_data_i   = '0;
    aw_ready_i  = 1'b0;
    ar_ready_i  = 1'b0;
    w_ready_i   = 1'b0;
    r_valid_i   = 1'b0;
    r_i         = '0;
    b_valid_i   = 1'b0;
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // Idle outputs straight after reset
    start = errors + checker_fails();
    @(negedge clk_i);
    check_val("req_ready_o", req_ready_o, 1);
    check_val("ar_valid_o", ar_valid_o, 0);
    check_val("aw_valid_o", aw_valid_o, 0);
    check_val("w_valid_o", w_valid_o, 0);
    check_val("r_ready_o", r_ready_o, 0);
    check_val("b_ready_o", b_ready_o, 0);
    check_val("ld_valid_o", ld_valid_o, 0);
    check_val("req_done_o", req_done_o, 0);
    finish_test("reset", start);

    start = errors + checker_fails();
    run_req(32'h0000_1000, 40, 1'b1);
    wait_done();
    finish_test("load split", start);

    start = errors + checker_fails();
    run_req(32'h0000_0fe0, 20, 1'b1);
    wait_done();
    finish_test("page crossing", start);

    start = errors + checker_fails();
    run_req(32'h0000_9000, 10, 1'b0);
    wait_done();
    finish_test("store", start);

    // Four requests against throttled AR, AW and W
    start = errors + checker_fails();
    @(negedge clk_i);
    throttle = 1'b1;
    run_req(32'h0000_3fd8, 24, 1'b1);
    run_req(32'h0000_5000, 12, 1'b0);
    run_req(32'h0000_6000, 30, 1'b1);
    run_req(32'h0000_7f80, 17, 1'b0);
    wait_done();
    @(negedge clk_i);
    throttle = 1'b0;
    finish_test("back-pressure", start);

    start = errors + checker_fails();
    write_cfg(4'(cfg_addr_max_beats), 32'd3);
    run_req(32'h0000_8000, 9, 1'b1);
    wait_done();
    finish_test("config cap", start);

    $display("tests run %0d, failed %0d, compare errors %0d, assertion errors %0d",
             tests_run, tests_failed, errors, checker_fails());
    if (tests_failed == 0 && errors == 0 && checker_fails() == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== project.f ====
common/vlsu_pkg.sv
hw/vlsu_cfg_regs.sv
hw/vlsu_seg_split.sv
hw/txn_ctrl/txn_ctrl_unit.sv
hw/vlsu_beat_track.sv
hw/vlsu_top.sv
dv/vlsu_checker.sv
dv/tb_vlsu.sv

// ==== Makefile ====
# Verilator simulation of the VLSU memory front end

VERILATOR   ?= verilator
TOP         ?= tb_vlsu
FILELIST    ?= project.f
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
ERROR_LIMIT ?= 1000
VFLAGS      ?= --binary --timing --assert -Wno-fatal
PASS_MSG    := TESTBENCH PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG ERROR_LIMIT VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) +verilator+error+limit+$(ERROR_LIMIT) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
